// File: sim/space_game_golden.txt
// columns (hex): op x y wait rgb won over stage, rgb 100 = not checked
// op 1 start 2 pause 3 win 4 skip 5 tick(x frames) 6 pixel 7 scan(x obj, y frames) 8 idle 0 end
8 0 0 0 01 0 0 0
6 136 195 3 01 0 0 0
1 1 0 3 1c 0 0 0
6 0 0 1 01 0 0 0
7 1 0 0 100 0 0 0
5 14 0 1 01 0 0 0
7 1 14 0 100 0 0 0
7 0 14 0 100 0 0 0
6 aa 50 1 e0 0 0 0
2 1 0 3 01 0 0 0
5 5 0 1 01 0 0 0
2 0 0 3 e0 0 0 0
5 a 0 2 01 0 0 0
7 1 1e 0 100 0 0 0
7 0 1e 0 100 0 0 0
3 0 0 2 01 0 0 1
7 1 0 0 100 0 0 1
4 1 0 2 01 0 0 2
4 0 0 1 01 0 0 2
7 3 0 0 100 0 0 2
5 3c 0 1 01 0 0 2
7 3 3c 0 100 0 0 2
7 0 5a 0 100 0 0 2
5 a 0 1 01 0 0 2
6 1f9 195 1 1c 0 0 2
8 0 0 1 01 0 1 2
1 0 0 1 01 0 0 0
6 0 0 1 01 0 0 0
1 1 0 3 01 0 0 0
3 0 0 2 01 0 0 1
3 0 0 2 01 0 0 2
4 1 0 2 01 0 0 3
4 0 0 1 01 0 0 3
3 0 0 2 01 1 0 4
8 0 0 2 01 1 0 4
3 0 0 2 01 1 0 4
1 0 0 1 01 0 0 0
0 0 0 0 0 0 0 0

// File: files.f
common/game_pkg.sv
game_control/stage_controller.sv
game_control/game_controller.sv
verilog/object_unit.sv
verilog/draw_arbiter.sv
verilog/space_game_top.sv
sim/game_controller_assertions.sv
sim/space_game_tb.sv

// File: Bender.yml
package:
  name: space_game

sources:
  - common/game_pkg.sv
  - game_control/stage_controller.sv
  - game_control/game_controller.sv
  - verilog/object_unit.sv
  - verilog/draw_arbiter.sv
  - verilog/space_game_top.sv
  - target: simulation
    files:
      - sim/game_controller_assertions.sv
      - sim/space_game_tb.sv

// File: sim/space_game_tb.sv
// space game testbench
// replays the golden records against the game top level and checks
// colour, stage number and the won and over flags

`timescale 1ns/100ps
`default_nettype none

module space_game_tb;
    import game_pkg::*;

    localparam int RECORD_WORDS = 8;   // op x y wait rgb won over stage
    localparam int MAX_RECORDS  = 64;
    localparam int SCAN_POINTS  = 6;   // random pixels per scan record
    localparam int RESET_CYCLES = 10;

    localparam logic [15:0] OP_END   = 16'h0;
    localparam logic [15:0] OP_START = 16'h1;
    localparam logic [15:0] OP_PAUSE = 16'h2;
    localparam logic [15:0] OP_WIN   = 16'h3;
    localparam logic [15:0] OP_SKIP  = 16'h4;
    localparam logic [15:0] OP_TICK  = 16'h5;
    localparam logic [15:0] OP_PIXEL = 16'h6;
    localparam logic [15:0] OP_SCAN  = 16'h7;
    localparam logic [15:0] OP_IDLE  = 16'h8;
    localparam logic [15:0] RGB_ANY  = 16'h100;  // rgb not checked

    logic   clk = 1'b0;
    logic   resetN;
    logic   start_game;
    logic   pause;
    logic   skip_stage;
    logic   win_stage;
    logic   frame_tick;
    coord_t pixel_x;
    coord_t pixel_y;
    rgb_t   rgb;
    logic   game_won;
    logic   game_over;
    stage_t stage_num;

    logic [15:0] golden [0:RECORD_WORDS*MAX_RECORDS-1];
    int seed            = 32'h32a3;
    int watchdog_cycles = 0;
    int assert_fails;

    // objects as placed by the top level: player, monster, boss, asteroid
    int   obj_x0  [4] = '{300, 100, 260, 500};
    int   obj_y0  [4] = '{400, 50, 40, 120};
    int   obj_w   [4] = '{32, 24, 64, 16};
    int   obj_h   [4] = '{16, 24, 32, 16};
    int   obj_dx  [4] = '{2, 3, 1, 0};
    int   obj_dy  [4] = '{0, 1, 0, 4};
    rgb_t obj_rgb [4] = '{8'h1c, 8'he0, 8'he3, 8'hb5};

    always #4 clk = ~clk;

    space_game_top u_space_game_top (
        .clk        (clk),
        .resetN     (resetN),
        .start_game (start_game),
        .pause      (pause),
        .skip_stage (skip_stage),
        .win_stage  (win_stage),
        .frame_tick (frame_tick),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .rgb        (rgb),
        .game_won   (game_won),
        .game_over  (game_over),
        .stage_num  (stage_num)
    );

    assign assert_fails = u_space_game_top.u_game_controller.u_game_controller_assertions.fail_count;

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_edges(input int n);
        repeat (n) begin
            @(posedge clk);
            win_stage  <= 1'b0;  // strobes last one cycle
            frame_tick <= 1'b0;
        end
    endtask

    task automatic send_ticks(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            if (i > 0) begin
                @(posedge clk);
                frame_tick <= 1'b0;  // idle cycle between frames
                @(posedge clk);
            end
            frame_tick <= 1'b1;
        end
    endtask

    // random pixels inside one object's box, expected colour is the object's
    task automatic scan_box(input int id, input int frames);
        int bx;
        int by;
        int i;
        bx = (obj_x0[id] + frames * obj_dx[id]) % SCREEN_W;
        by = (obj_y0[id] + frames * obj_dy[id]) % SCREEN_H;
        for (i = 0; i < SCAN_POINTS; i++) begin
            if (i > 0)
                @(posedge clk);
            pixel_x <= coord_t'(bx + $unsigned($random(seed)) % obj_w[id]);
            pixel_y <= coord_t'(by + $unsigned($random(seed)) % obj_h[id]);
            @(posedge clk);
            @(negedge clk);  // rgb one cycle after the pixel
            check_value("scan rgb", rgb, obj_rgb[id]);
        end
        @(posedge clk);
        pixel_x <= '0;
        pixel_y <= '0;
    endtask

    always @(assert_fails) begin
        if (assert_fails != 0) begin
            $display("A controller assertion failed at %0t ns", $time);
            $display("Done: errors found");
            $fatal(1, "controller assertions failed");
        end
    end

    initial begin
        int          rec;
        int          base;
        int          n_records;
        int          budget;
        logic [15:0] op;
        logic [15:0] arg_x;
        logic [15:0] arg_y;
        logic [15:0] wait_n;

        resetN     = 1'b0;
        start_game = 1'b0;
        pause      = 1'b0;
        skip_stage = 1'b0;
        win_stage  = 1'b0;
        frame_tick = 1'b0;
        pixel_x    = '0;
        pixel_y    = '0;

        $readmemh("sim/space_game_golden.txt", golden);
        n_records = 0;
        budget    = 0;
        while (n_records < MAX_RECORDS && golden[n_records*RECORD_WORDS] != OP_END) begin
            base   = n_records * RECORD_WORDS;
            budget += golden[base+3] + 1;
            if (golden[base] == OP_TICK)
                budget += 2 * golden[base+1];
            if (golden[base] == OP_SCAN)
                budget += 2 * SCAN_POINTS + 1;
            n_records++;
        end
        if (n_records == 0) begin
            $display("Golden file sim/space_game_golden.txt is missing or holds no records");
            $display("Done: errors found");
            $fatal(1, "no stimulus");
        end
        watchdog_cycles = budget + RESET_CYCLES + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        resetN <= 1'b1;

        for (rec = 0; rec < n_records; rec++) begin
            base   = rec * RECORD_WORDS;
            op     = golden[base];
            arg_x  = golden[base+1];
            arg_y  = golden[base+2];
            wait_n = golden[base+3];

            @(posedge clk);
            win_stage  <= 1'b0;
            frame_tick <= 1'b0;
            case (op)
                OP_START: start_game <= arg_x[0];
                OP_PAUSE: pause      <= arg_x[0];
                OP_WIN:   win_stage  <= 1'b1;
                OP_SKIP:  skip_stage <= arg_x[0];  // level, edge found inside
                OP_TICK:  send_ticks(arg_x);
                OP_PIXEL: begin
                    pixel_x <= arg_x[10:0];
                    pixel_y <= arg_y[10:0];
                end
                OP_SCAN:  scan_box(arg_x, arg_y);
                OP_IDLE:  ;
                default: begin
                    $display("Golden record %0d has an unknown opcode %0h", rec, op);
                    $display("Done: errors found");
                    $fatal(1, "bad golden record");
                end
            endcase
            wait_edges(wait_n);
            @(negedge clk);

            if (golden[base+4] != RGB_ANY)
                check_value("rgb", rgb, golden[base+4]);
            check_value("game_won", game_won, golden[base+5]);
            check_value("game_over", game_over, golden[base+6]);
            check_value("stage_num", stage_num, golden[base+7]);
        end

        $display("Done: no errors");
        $finish;
    end

    // cycle budget from the golden records
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: sim/game_controller_assertions.sv
// controller checks
// bound into the game controller, watches the stage range, the win flag
// and the object enables while the game sits in reset

`timescale 1ns/100ps
`default_nettype none

module game_controller_assertions (
    input logic             clk,
    input logic             resetN,
    input logic             game_won,
    input logic             enable_player,
    input logic             enable_monst,
    input logic             enable_boss,
    input logic             enable_astero,
    input logic             clear_player,
    input game_pkg::stage_t stage_num
);
    import game_pkg::*;

    int fail_count = 0;

    stage_in_range: assert property (@(posedge clk) disable iff (!resetN)
        stage_num <= LAST_STAGE)
        else begin
            $error("stage_num went past the last stage");
            fail_count++;
        end

    won_at_last_stage: assert property (@(posedge clk) disable iff (!resetN)
        game_won |-> (stage_num == LAST_STAGE))
        else begin
            $error("game_won is set before the last stage");
            fail_count++;
        end

    // clear_player is only active in RESET
    quiet_in_reset: assert property (@(posedge clk) disable iff (!resetN)
        clear_player |-> !(enable_player | enable_monst | enable_boss | enable_astero))
        else begin
            $error("object enable active in RESET");
            fail_count++;
        end

endmodule

bind game_controller game_controller_assertions u_game_controller_assertions (
    .clk           (clk),
    .resetN        (resetN),
    .game_won      (game_won),
    .enable_player (enable_player),
    .enable_monst  (enable_monst),
    .enable_boss   (enable_boss),
    .enable_astero (enable_astero),
    .clear_player  (clear_player),
    .stage_num     (stage_num)
);

`default_nettype wire

// File: verilog/space_game_top.sv
// space game top
// controller, four moving objects and the draw arbiter

`timescale 1ns/100ps
`default_nettype none

module space_game_top (
    input  logic             clk,
    input  logic             resetN,
    input  logic             start_game,
    input  logic             pause,
    input  logic             skip_stage,
    input  logic             win_stage,
    input  logic             frame_tick,
    input  game_pkg::coord_t pixel_x,
    input  game_pkg::coord_t pixel_y,
    output game_pkg::rgb_t   rgb,
    output logic             game_won,
    output logic             game_over,
    output game_pkg::stage_t stage_num
);
    import game_pkg::*;

    logic enable_player;
    logic enable_monst;
    logic enable_boss;
    logic enable_astero;
    logic clear_player;
    logic clear_monst;
    logic player_hit;
    logic player_req;
    logic monst_req;
    logic boss_req;
    logic astero_req;
    rgb_t player_rgb;
    rgb_t monst_rgb;
    rgb_t boss_rgb;
    rgb_t astero_rgb;

    game_controller u_game_controller (
        .clk           (clk),
        .resetN        (resetN),
        .start_game    (start_game),
        .pause         (pause),
        .skip_stage    (skip_stage),
        .win_stage     (win_stage),
        .player_dead   (player_hit),
        .game_won      (game_won),
        .game_over     (game_over),
        .enable_player (enable_player),
        .enable_monst  (enable_monst),
        .enable_boss   (enable_boss),
        .enable_astero (enable_astero),
        .clear_player  (clear_player),
        .clear_monst   (clear_monst),
        .stage_num     (stage_num)
    );

    // player, green, slides right near the bottom
    object_unit #(
        .START_X (11'd300), .START_Y (11'd400), .OBJ_W (11'd32), .OBJ_H (11'd16),
        .STEP_X  (11'd2),   .STEP_Y  (11'd0),   .COLOR (8'b000_111_00)
    ) u_player (
        .clk (clk), .resetN (resetN), .enable (enable_player), .clear (clear_player),
        .frame_tick (frame_tick), .pixel_x (pixel_x), .pixel_y (pixel_y),
        .draw_req (player_req), .color (player_rgb)
    );

    // monster, red, drifts diagonally
    object_unit #(
        .START_X (11'd100), .START_Y (11'd50),  .OBJ_W (11'd24), .OBJ_H (11'd24),
        .STEP_X  (11'd3),   .STEP_Y  (11'd1),   .COLOR (8'b111_000_00)
    ) u_monster (
        .clk (clk), .resetN (resetN), .enable (enable_monst), .clear (clear_monst),
        .frame_tick (frame_tick), .pixel_x (pixel_x), .pixel_y (pixel_y),
        .draw_req (monst_req), .color (monst_rgb)
    );

    // boss, magenta, wide and slow
    object_unit #(
        .START_X (11'd260), .START_Y (11'd40),  .OBJ_W (11'd64), .OBJ_H (11'd32),
        .STEP_X  (11'd1),   .STEP_Y  (11'd0),   .COLOR (8'b111_000_11)
    ) u_boss (
        .clk (clk), .resetN (resetN), .enable (enable_boss), .clear (clear_monst),
        .frame_tick (frame_tick), .pixel_x (pixel_x), .pixel_y (pixel_y),
        .draw_req (boss_req), .color (boss_rgb)
    );

    // asteroid, grey, falls straight down
    object_unit #(
        .START_X (11'd500), .START_Y (11'd120), .OBJ_W (11'd16), .OBJ_H (11'd16),
        .STEP_X  (11'd0),   .STEP_Y  (11'd4),   .COLOR (8'b101_101_01)
    ) u_asteroid (
        .clk (clk), .resetN (resetN), .enable (enable_astero), .clear (clear_monst),
        .frame_tick (frame_tick), .pixel_x (pixel_x), .pixel_y (pixel_y),
        .draw_req (astero_req), .color (astero_rgb)
    );

    draw_arbiter u_draw_arbiter (
        .clk        (clk),
        .resetN     (resetN),
        .player_req (player_req),
        .boss_req   (boss_req),
        .monst_req  (monst_req),
        .astero_req (astero_req),
        .player_rgb (player_rgb),
        .boss_rgb   (boss_rgb),
        .monst_rgb  (monst_rgb),
        .astero_rgb (astero_rgb),
        .rgb        (rgb),
        .player_hit (player_hit)
    );

endmodule

`default_nettype wire

// File: verilog/draw_arbiter.sv
// draw arbiter
// fixed priority owner of the pixel colour output, registered,
// and collision detect between the player and any hostile

`timescale 1ns/100ps
`default_nettype none

module draw_arbiter (
    input  logic           clk,
    input  logic           resetN,
    input  logic           player_req,
    input  logic           boss_req,
    input  logic           monst_req,
    input  logic           astero_req,
    input  game_pkg::rgb_t player_rgb,
    input  game_pkg::rgb_t boss_rgb,
    input  game_pkg::rgb_t monst_rgb,
    input  game_pkg::rgb_t astero_rgb,
    output game_pkg::rgb_t rgb,
    output logic           player_hit
);
    import game_pkg::*;

    rgb_t rgb_next;
    logic hit_next;

    // player wins over everything, background last
    always_comb begin
        if (player_req)
            rgb_next = player_rgb;
        else if (boss_req)
            rgb_next = boss_rgb;
        else if (monst_req)
            rgb_next = monst_rgb;
        else if (astero_req)
            rgb_next = astero_rgb;
        else
            rgb_next = BACKGROUND_RGB;
    end

    assign hit_next = player_req & (boss_req | monst_req | astero_req);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            rgb        <= BACKGROUND_RGB;
            player_hit <= 1'b0;
        end else begin
            rgb        <= rgb_next;
            player_hit <= hit_next;  // same pixel, same cycle as rgb
        end
    end

endmodule

`default_nettype wire

// File: verilog/object_unit.sv
// moving object
// a rectangle that steps once per frame with screen wrap-around and
// requests the pixel colour when the scan is inside it

`timescale 1ns/100ps
`default_nettype none

module object_unit #(
    parameter game_pkg::coord_t START_X = '0,
    parameter game_pkg::coord_t START_Y = '0,
    parameter game_pkg::coord_t OBJ_W   = 11'd16,
    parameter game_pkg::coord_t OBJ_H   = 11'd16,
    parameter game_pkg::coord_t STEP_X  = 11'd1,
    parameter game_pkg::coord_t STEP_Y  = 11'd0,
    parameter game_pkg::rgb_t   COLOR   = 8'hff
) (
    input  logic             clk,
    input  logic             resetN,
    input  logic             enable,
    input  logic             clear,
    input  logic             frame_tick,
    input  game_pkg::coord_t pixel_x,
    input  game_pkg::coord_t pixel_y,
    output logic             draw_req,
    output game_pkg::rgb_t   color
);
    import game_pkg::*;

    coord_t x_pos;  // top left corner
    coord_t y_pos;

    // pos + step, folded back into [0, limit)
    function automatic coord_t wrap_add(input coord_t pos, input coord_t step,
                                        input coord_t limit);
        logic [11:0] sum;
        sum = {1'b0, pos} + {1'b0, step};
        if (sum >= {1'b0, limit})
            sum = sum - {1'b0, limit};
        return sum[10:0];
    endfunction

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_pos <= START_X;
            y_pos <= START_Y;
        end else if (clear) begin
            x_pos <= START_X;
            y_pos <= START_Y;
        end else if (enable && frame_tick) begin
            x_pos <= wrap_add(x_pos, STEP_X, SCREEN_W);
            y_pos <= wrap_add(y_pos, STEP_Y, SCREEN_H);
        end
    end

    assign draw_req = enable &&
                      (pixel_x >= x_pos) && (pixel_x < x_pos + OBJ_W) &&
                      (pixel_y >= y_pos) && (pixel_y < y_pos + OBJ_H);

    assign color = COLOR;

endmodule

`default_nettype wire

// File: game_control/game_controller.sv
// game controller
// top level FSM of the game: reset, run, pause, stage won and game over.
// samples the switches, makes the skip pulse and gates the object enables

`timescale 1ns/100ps
`default_nettype none

module game_controller (
    input  logic             clk,
    input  logic             resetN,
    input  logic             start_game,
    input  logic             pause,
    input  logic             skip_stage,
    input  logic             win_stage,
    input  logic             player_dead,
    output logic             game_won,
    output logic             game_over,
    output logic             enable_player,
    output logic             enable_monst,
    output logic             enable_boss,
    output logic             enable_astero,
    output logic             clear_player,
    output logic             clear_monst,
    output game_pkg::stage_t stage_num
);
    import game_pkg::*;

    typedef enum logic [2:0] {RESET, RUN, PAUSE, STAGE_WON, GAME_OVER} state_t;

    state_t pres_st;
    state_t next_st;
    logic   start_s;
    logic   pause_s;
    logic   skip_s;
    logic   skip_d;
    logic   win_s;
    logic   skip_pulse;
    logic   stage_advance;
    logic   run_en;
    logic   stage_monst;
    logic   stage_boss;
    logic   stage_astero;

    // one register on every switch and strobe
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            start_s <= 1'b0;
            pause_s <= 1'b0;
            skip_s  <= 1'b0;
            skip_d  <= 1'b0;
            win_s   <= 1'b0;
        end else begin
            start_s <= start_game;
            pause_s <= pause;
            skip_s  <= skip_stage;
            skip_d  <= skip_s;   // previous skip level
            win_s   <= win_stage;
        end
    end

    assign skip_pulse = skip_s & ~skip_d;

    // same conditions as the RUN -> STAGE_WON transition below
    assign stage_advance = (pres_st == RUN) && start_game && !pause_s && !player_dead &&
                           (win_s || skip_pulse);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN)
            pres_st <= RESET;
        else
            pres_st <= next_st;
    end

    always_comb begin
        next_st       = pres_st;
        enable_player = 1'b0;
        run_en        = 1'b0;
        clear_player  = 1'b0;
        clear_monst   = 1'b0;
        game_over     = 1'b0;

        case (pres_st)
            RESET: begin
                clear_player = 1'b1;
                clear_monst  = 1'b1;
                if (start_s) next_st = RUN;
            end
            RUN: begin
                enable_player = 1'b1;
                run_en        = 1'b1;
                if (pause_s)                   next_st = PAUSE;
                else if (player_dead)          next_st = GAME_OVER;
                else if (win_s || skip_pulse)  next_st = STAGE_WON;
            end
            PAUSE: begin
                // everything frozen, positions held
                if (!pause_s) next_st = RUN;
            end
            STAGE_WON: begin
                enable_player = 1'b1;
                clear_monst   = 1'b1;  // hostiles restart for the new stage
                if (stage_num == LAST_STAGE)
                    next_st = GAME_OVER;
                else
                    next_st = RUN;
            end
            GAME_OVER: begin
                clear_monst = 1'b1;
                game_over   = !game_won;  // a won game is not reported as lost
            end
            default: next_st = RESET;
        endcase

        // switch off overrides any state
        if (!start_game) next_st = RESET;
    end

    stage_controller u_stage_controller (
        .clk           (clk),
        .resetN        (resetN),
        .start_game    (start_game),
        .stage_advance (stage_advance),
        .game_won      (game_won),
        .enable_monst  (stage_monst),
        .enable_boss   (stage_boss),
        .enable_astero (stage_astero),
        .stage_num     (stage_num)
    );

    assign enable_monst  = run_en & stage_monst;
    assign enable_boss   = run_en & stage_boss;
    assign enable_astero = run_en & stage_astero;

endmodule

`default_nettype wire

// File: game_control/stage_controller.sv
// stage tracker
// counts the five stages and picks which hostile group is active

`timescale 1ns/100ps
`default_nettype none

module stage_controller (
    input  logic             clk,
    input  logic             resetN,
    input  logic             start_game,
    input  logic             stage_advance,
    output logic             game_won,
    output logic             enable_monst,
    output logic             enable_boss,
    output logic             enable_astero,
    output game_pkg::stage_t stage_num
);
    import game_pkg::*;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_num <= '0;
            game_won  <= 1'b0;
        end else if (!start_game) begin
            stage_num <= '0;  // new game starts from stage 0
            game_won  <= 1'b0;
        end else if (stage_advance && (stage_num != LAST_STAGE)) begin
            stage_num <= stage_num + stage_t'(1);
            if (stage_num == LAST_STAGE - stage_t'(1))
                game_won <= 1'b1;  // held until the switch goes off
        end
    end

    // hostile group for each stage
    always_comb begin
        enable_monst  = 1'b0;
        enable_boss   = 1'b0;
        enable_astero = 1'b0;
        case (stage_num)
            stage_t'(0), stage_t'(1): enable_monst  = 1'b1;
            stage_t'(2):              enable_astero = 1'b1;
            stage_t'(3):              enable_boss   = 1'b1;
            default: ;                // last stage, nothing left to fight
        endcase
    end

endmodule

`default_nettype wire

// File: common/game_pkg.sv
// game package
// shared colour, coordinate and stage types for the space shooter,
// plus screen size and the background colour

`default_nettype none

package game_pkg;

    // 3 bits red, 3 bits green, 2 bits blue
    typedef logic [7:0] rgb_t;

    // unsigned pixel coordinate
    typedef logic [10:0] coord_t;

    // stage number, 0 to 4
    typedef logic [2:0] stage_t;

    // visible screen area
    localparam coord_t SCREEN_W = coord_t'(640);
    localparam coord_t SCREEN_H = coord_t'(480);

    // reaching this stage wins the game
    localparam stage_t LAST_STAGE = stage_t'(4);

    localparam rgb_t BACKGROUND_RGB = 8'b000_000_01;  // dark blue sky

endpackage

`default_nettype wire
